/* logic/cacheAddrPkg.sv */
package cacheAddrPkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0]  byteEn_t;

	// area codes in address bits 31..29
	localparam logic [2:0] AREA_CACHED   = 3'b000;
	localparam logic [2:0] AREA_UNCACHED = 3'b001;
	localparam logic [2:0] AREA_IO       = 3'b111;

	// address split: tag 28..10, set 9..4, word 3..2
	localparam int TAG_W   = 19;
	localparam int INDEX_W = 6;
	localparam int WORD_W  = 2;

	typedef logic [TAG_W-1:0]   tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [WORD_W-1:0]  wordSel_t;

	localparam int WAYS = 4;

	// one-hot way select
	typedef logic [WAYS-1:0] wayMask_t;

	// control register lives on byte lane 1
	localparam addr_t CCR_ADDR = 32'hFFFF_FE92;

endpackage

/* logic/cacheCtrlPkg.sv */
package cacheCtrlPkg;

	typedef logic [7:0] ccr_t;

	localparam int CCR_CE_BIT = 0;
	localparam int CCR_CP_BIT = 4;

	// only the enable bit is stored
	localparam ccr_t CCR_WMASK = ccr_t'(8'h01 << CCR_CE_BIT);

	typedef enum logic [1:0] {
		IDLE,
		PASS_READ,
		PASS_WRITE,
		FILL
	} ctrlState_t;

	// pairwise use order per set
	// bit 5: way1 after way0
	// bit 4: way2 after way0
	// bit 3: way3 after way0
	// bit 2: way2 after way1
	// bit 1: way3 after way1
	// bit 0: way3 after way2
	typedef logic [5:0] lru_t;

endpackage

/* logic/lineFillCounter.sv */
`timescale 1ns/1ps

module lineFillCounter (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic                   start,
	input  cacheAddrPkg::wordSel_t startWord,
	input  logic                   advance,
	output cacheAddrPkg::wordSel_t word,
	output logic                   last,
	output logic                   unlock
);
	import cacheAddrPkg::*;

	wordSel_t critWord;
	wordSel_t beforeCrit;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			word <= '0;
			critWord <= '0;
		end else if (start) begin
			// critical word goes last
			word <= startWord + 1'b1;
			critWord <= startWord;
		end else if (advance) begin
			word <= word + 1'b1;
		end
	end

	assign beforeCrit = critWord - 1'b1;
	assign last = word == critWord;
	assign unlock = word == beforeCrit;

endmodule

/* logic/tagArray.sv */
`timescale 1ns/1ps

module tagArray #(
	parameter int SETS = 64
) (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  cacheAddrPkg::addr_t    lookupAddr,
	input  cacheAddrPkg::addr_t    wrAddr,
	input  cacheAddrPkg::wayMask_t wrWay,
	input  logic                   tagWrite,
	input  logic                   purge,
	output cacheAddrPkg::wayMask_t hitWay,
	output logic                   hit
);
	import cacheAddrPkg::*;

	localparam int SET_BITS = $clog2(SETS);
	localparam int IDX_LSB = WORD_W + 2;
	localparam int TAG_LSB = IDX_LSB + INDEX_W;

	tag_t                tags [WAYS][SETS];
	logic [SETS-1:0]     valid [WAYS];
	logic [SET_BITS-1:0] rdIdx;
	logic [SET_BITS-1:0] wrIdx;
	tag_t                rdTag;

	assign rdIdx = lookupAddr[IDX_LSB +: SET_BITS];
	assign wrIdx = wrAddr[IDX_LSB +: SET_BITS];
	assign rdTag = lookupAddr[TAG_LSB +: TAG_W];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int w = 0; w < WAYS; w++) begin
				valid[w] <= '0;
			end
		end else if (purge) begin
			for (int w = 0; w < WAYS; w++) begin
				valid[w] <= '0;
			end
		end else if (tagWrite) begin
			for (int w = 0; w < WAYS; w++) begin
				if (wrWay[w]) begin
					valid[w][wrIdx] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		for (int w = 0; w < WAYS; w++) begin
			if (tagWrite && wrWay[w]) begin
				tags[w][wrIdx] <= wrAddr[TAG_LSB +: TAG_W];
			end
		end
	end

	// all four ways compared at once
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			hitWay[w] = valid[w][rdIdx] && tags[w][rdIdx] == rdTag;
		end
	end

	assign hit = |hitWay;

endmodule

/* logic/dataArray.sv */
`timescale 1ns/1ps

module dataArray #(
	parameter int SETS = 64
) (
	input  logic                   CLK,
	input  cacheAddrPkg::addr_t    rdAddr,
	input  cacheAddrPkg::wayMask_t rdWay,
	input  cacheAddrPkg::addr_t    wrAddr,
	input  cacheAddrPkg::wayMask_t wrWay,
	input  cacheAddrPkg::byteEn_t  wrBytes,
	input  cacheAddrPkg::word_t    wrData,
	output cacheAddrPkg::word_t    rdData
);
	import cacheAddrPkg::*;

	// set and word within line form the row
	localparam int ROW_BITS = $clog2(SETS) + WORD_W;
	localparam int ROWS = SETS << WORD_W;
	localparam int LANES = $bits(byteEn_t);

	word_t               mem [WAYS][ROWS];
	logic [ROW_BITS-1:0] rdRow;
	logic [ROW_BITS-1:0] wrRow;

	assign rdRow = rdAddr[2 +: ROW_BITS];
	assign wrRow = wrAddr[2 +: ROW_BITS];

	always_ff @(posedge CLK) begin
		for (int w = 0; w < WAYS; w++) begin
			for (int b = 0; b < LANES; b++) begin
				if (wrWay[w] && wrBytes[b]) begin
					mem[w][wrRow][8*b +: 8] <= wrData[8*b +: 8];
				end
			end
		end
	end

	// one-hot way select
	always_comb begin
		rdData = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (rdWay[w]) begin
				rdData = rdData | mem[w][rdRow];
			end
		end
	end

endmodule

/* logic/lruStore.sv */
`timescale 1ns/1ps

module lruStore #(
	parameter int SETS = 64
) (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  cacheAddrPkg::addr_t    lookupAddr,
	input  cacheAddrPkg::addr_t    touchAddr,
	input  cacheAddrPkg::wayMask_t touchWay,
	input  logic                   touch,
	input  logic                   purge,
	output cacheAddrPkg::wayMask_t victimWay
);
	import cacheAddrPkg::*;
	import cacheCtrlPkg::*;

	localparam int SET_BITS = $clog2(SETS);

	lru_t                lru [SETS];
	lru_t                cur;
	wayMask_t            oldest;
	logic [SET_BITS-1:0] rdIdx;
	logic [SET_BITS-1:0] wrIdx;

	// touched way becomes the later one of each of its pairs
	function automatic lru_t touched(input wayMask_t way, input lru_t v);
		lru_t r;
		r = v;
		if (way[0]) begin
			r[5:3] = 3'b000;
		end
		if (way[1]) begin
			r[5] = 1'b1;
			r[2:1] = 2'b00;
		end
		if (way[2]) begin
			r[4] = 1'b1;
			r[2] = 1'b1;
			r[0] = 1'b0;
		end
		if (way[3]) begin
			r[3] = 1'b1;
			r[1:0] = 2'b11;
		end
		return r;
	endfunction

	assign rdIdx = lookupAddr[WORD_W+2 +: SET_BITS];
	assign wrIdx = touchAddr[WORD_W+2 +: SET_BITS];
	assign cur = lru[rdIdx];

	// oldest way is used before all three others
	assign oldest[0] = cur[5] && cur[4] && cur[3];
	assign oldest[1] = !cur[5] && cur[2] && cur[1];
	assign oldest[2] = !cur[4] && !cur[2] && cur[0];
	assign oldest[3] = !cur[3] && !cur[1] && !cur[0];
	assign victimWay = oldest;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int s = 0; s < SETS; s++) begin
				lru[s] <= '0;
			end
		end else if (purge) begin
			for (int s = 0; s < SETS; s++) begin
				lru[s] <= '0;
			end
		end else if (touch) begin
			lru[wrIdx] <= touched(touchWay, lru[wrIdx]);
		end
	end

endmodule

/* logic/ccrRegister.sv */
`timescale 1ns/1ps

module ccrRegister (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  cacheAddrPkg::addr_t   ibusAddr,
	input  cacheAddrPkg::word_t   ibusDataOut,
	input  cacheAddrPkg::byteEn_t ibusByteEn,
	input  logic                  ibusWrite,
	input  logic                  ibusReq,
	input  logic                  ibusWait,
	output logic                  selected,
	output logic                  cacheEnable,
	output logic                  purge,
	output cacheAddrPkg::word_t   readWord
);
	import cacheAddrPkg::*;
	import cacheCtrlPkg::*;

	ccr_t ccr;
	ccr_t laneByte;
	logic wrAccept;

	// register sits on byte lane 1
	assign selected = ibusReq && ibusAddr == CCR_ADDR && ibusByteEn[1];
	assign laneByte = ibusDataOut[15:8];
	assign wrAccept = selected && ibusWrite && !ibusWait;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ccr <= '0;
		end else if (wrAccept) begin
			ccr <= laneByte & CCR_WMASK;
		end
	end

	// purge pulse lasts for the accepted write only
	assign purge = wrAccept && laneByte[CCR_CP_BIT];
	assign cacheEnable = ccr[CCR_CE_BIT];
	assign readWord = {4{ccr}};

endmodule

/* logic/cacheController.sv */
`timescale 1ns/1ps

module cacheController (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  cacheAddrPkg::addr_t    cbusAddr,
	input  cacheAddrPkg::word_t    cbusDataIn,
	input  logic                   cbusWrite,
	input  logic                   cbusReq,
	input  cacheAddrPkg::byteEn_t  cbusByteEn,
	output logic                   cbusBusy,
	output cacheAddrPkg::word_t    cbusDataOut,
	output cacheAddrPkg::addr_t    ibusAddr,
	input  cacheAddrPkg::word_t    ibusDataIn,
	output cacheAddrPkg::word_t    ibusDataOut,
	output cacheAddrPkg::byteEn_t  ibusByteEn,
	output logic                   ibusWrite,
	output logic                   ibusReq,
	output logic                   ibusLock,
	input  logic                   ibusWait,
	input  logic                   hit,
	input  cacheAddrPkg::wayMask_t hitWay,
	input  cacheAddrPkg::wayMask_t victimWay,
	input  cacheAddrPkg::word_t    cacheWord,
	input  logic                   cacheEnable,
	input  cacheAddrPkg::word_t    ccrReadWord,
	input  logic                   ccrSelected,
	output logic                   fillStart,
	input  cacheAddrPkg::wordSel_t fillWord,
	input  logic                   fillLast,
	input  logic                   fillUnlock,
	output logic                   beatAccepted,
	output cacheAddrPkg::addr_t    arrayWrAddr,
	output cacheAddrPkg::word_t    arrayWrData,
	output cacheAddrPkg::byteEn_t  arrayWrBytes,
	output cacheAddrPkg::wayMask_t arrayWrWay,
	output logic                   tagWrite,
	output logic                   lruTouch
);
	import cacheAddrPkg::*;
	import cacheCtrlPkg::*;

	ctrlState_t state;
	addr_t      reqAddr;
	word_t      reqData;
	byteEn_t    reqBytes;
	wayMask_t   fillWay;
	addr_t      fillAddr;
	logic       inIdle;
	logic       inFill;
	logic       cacheable;
	logic       readHit;
	logic       writeHit;
	logic       readMiss;

	assign inIdle = state == IDLE;
	assign inFill = state == FILL;
	assign cacheable = cacheEnable && cbusAddr[31:29] == AREA_CACHED;
	assign readHit = inIdle && cbusReq && !cbusWrite && cacheable && hit;
	assign writeHit = inIdle && cbusReq && cbusWrite && cacheable && hit;
	assign readMiss = inIdle && cbusReq && !cbusWrite && cacheable && !hit;

	assign fillStart = readMiss;
	assign beatAccepted = inFill && !ibusWait;
	// line base with the word from the fill counter
	assign fillAddr = {reqAddr[31:WORD_W+2], fillWord, 2'b00};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= IDLE;
			ibusReq <= 1'b0;
			ibusWrite <= 1'b0;
			ibusLock <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (cbusReq && cbusWrite) begin
						state <= PASS_WRITE;
						ibusReq <= 1'b1;
						ibusWrite <= 1'b1;
					end else if (cbusReq && !cacheable) begin
						state <= PASS_READ;
						ibusReq <= 1'b1;
					end else if (readMiss) begin
						state <= FILL;
						ibusReq <= 1'b1;
						ibusLock <= 1'b1;
					end
				end
				PASS_READ, PASS_WRITE: begin
					if (!ibusWait) begin
						state <= IDLE;
						ibusReq <= 1'b0;
						ibusWrite <= 1'b0;
					end
				end
				FILL: begin
					if (!ibusWait) begin
						// lock released once the third word is in
						if (fillUnlock) begin
							ibusLock <= 1'b0;
						end
						if (fillLast) begin
							state <= IDLE;
							ibusReq <= 1'b0;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (inIdle && cbusReq) begin
			reqAddr <= cbusAddr;
			reqData <= cbusDataIn;
			reqBytes <= readMiss ? '1 : cbusByteEn;
			fillWay <= victimWay;
		end
	end

	assign ibusAddr = inFill ? fillAddr : reqAddr;
	assign ibusDataOut = reqData;
	assign ibusByteEn = reqBytes;

	always_comb begin
		case (state)
			IDLE:                  cbusBusy = cbusReq && !readHit;
			PASS_READ, PASS_WRITE: cbusBusy = cbusReq && ibusWait;
			FILL:                  cbusBusy = cbusReq && !(beatAccepted && fillLast);
			default:               cbusBusy = cbusReq;
		endcase
	end

	always_comb begin
		case (state)
			IDLE:      cbusDataOut = cacheWord;
			PASS_READ: cbusDataOut = ccrSelected ? ccrReadWord : ibusDataIn;
			default:   cbusDataOut = ibusDataIn;
		endcase
	end

	// fills write whole words into the held way, write hits only the enabled lanes
	assign arrayWrAddr = inFill ? fillAddr : cbusAddr;
	assign arrayWrData = inFill ? ibusDataIn : cbusDataIn;
	assign arrayWrWay = inFill ? fillWay : hitWay;
	assign arrayWrBytes = beatAccepted ? '1 : (writeHit ? cbusByteEn : '0);
	assign tagWrite = beatAccepted;
	assign lruTouch = beatAccepted || readHit || writeHit;

endmodule

/* logic/cacheTop.sv */
`timescale 1ns/1ps

module cacheTop (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  cacheAddrPkg::addr_t    cbusAddr,
	input  cacheAddrPkg::word_t    cbusDataIn,
	output cacheAddrPkg::word_t    cbusDataOut,
	input  logic                   cbusWrite,
	input  logic                   cbusReq,
	input  cacheAddrPkg::byteEn_t  cbusByteEn,
	output logic                   cbusBusy,
	output cacheAddrPkg::addr_t    ibusAddr,
	input  cacheAddrPkg::word_t    ibusDataIn,
	output cacheAddrPkg::word_t    ibusDataOut,
	output cacheAddrPkg::byteEn_t  ibusByteEn,
	output logic                   ibusWrite,
	output logic                   ibusReq,
	output logic                   ibusLock,
	input  logic                   ibusWait
);
	import cacheAddrPkg::*;

	localparam int SETS = 64;

	logic     hit;
	wayMask_t hitWay;
	wayMask_t victimWay;
	word_t    cacheWord;
	logic     cacheEnable;
	logic     purge;
	word_t    ccrReadWord;
	logic     ccrSelected;
	logic     fillStart;
	wordSel_t fillWord;
	logic     fillLast;
	logic     fillUnlock;
	logic     beatAccepted;
	addr_t    arrayWrAddr;
	word_t    arrayWrData;
	byteEn_t  arrayWrBytes;
	wayMask_t arrayWrWay;
	logic     tagWrite;
	logic     lruTouch;

	cacheController ctrl (
		.CLK(CLK), .RST_N(RST_N),
		.cbusAddr(cbusAddr), .cbusDataIn(cbusDataIn), .cbusWrite(cbusWrite),
		.cbusReq(cbusReq), .cbusByteEn(cbusByteEn),
		.cbusBusy(cbusBusy), .cbusDataOut(cbusDataOut),
		.ibusAddr(ibusAddr), .ibusDataIn(ibusDataIn), .ibusDataOut(ibusDataOut),
		.ibusByteEn(ibusByteEn), .ibusWrite(ibusWrite), .ibusReq(ibusReq),
		.ibusLock(ibusLock), .ibusWait(ibusWait),
		.hit(hit), .hitWay(hitWay), .victimWay(victimWay), .cacheWord(cacheWord),
		.cacheEnable(cacheEnable), .ccrReadWord(ccrReadWord), .ccrSelected(ccrSelected),
		.fillStart(fillStart), .fillWord(fillWord), .fillLast(fillLast),
		.fillUnlock(fillUnlock), .beatAccepted(beatAccepted),
		.arrayWrAddr(arrayWrAddr), .arrayWrData(arrayWrData),
		.arrayWrBytes(arrayWrBytes), .arrayWrWay(arrayWrWay),
		.tagWrite(tagWrite), .lruTouch(lruTouch)
	);

	lineFillCounter fillCnt (
		.CLK(CLK), .RST_N(RST_N),
		.start(fillStart), .startWord(cbusAddr[3:2]), .advance(beatAccepted),
		.word(fillWord), .last(fillLast), .unlock(fillUnlock)
	);

	tagArray #(.SETS(SETS)) tags (
		.CLK(CLK), .RST_N(RST_N),
		.lookupAddr(cbusAddr), .wrAddr(arrayWrAddr), .wrWay(arrayWrWay),
		.tagWrite(tagWrite), .purge(purge), .hitWay(hitWay), .hit(hit)
	);

	dataArray #(.SETS(SETS)) data (
		.CLK(CLK),
		.rdAddr(cbusAddr), .rdWay(hitWay),
		.wrAddr(arrayWrAddr), .wrWay(arrayWrWay), .wrBytes(arrayWrBytes),
		.wrData(arrayWrData), .rdData(cacheWord)
	);

	lruStore #(.SETS(SETS)) lru (
		.CLK(CLK), .RST_N(RST_N),
		.lookupAddr(cbusAddr), .touchAddr(arrayWrAddr), .touchWay(arrayWrWay),
		.touch(lruTouch), .purge(purge), .victimWay(victimWay)
	);

	ccrRegister ccr (
		.CLK(CLK), .RST_N(RST_N),
		.ibusAddr(ibusAddr), .ibusDataOut(ibusDataOut), .ibusByteEn(ibusByteEn),
		.ibusWrite(ibusWrite), .ibusReq(ibusReq), .ibusWait(ibusWait),
		.selected(ccrSelected), .cacheEnable(cacheEnable), .purge(purge),
		.readWord(ccrReadWord)
	);

endmodule

/* verif/cacheModel.svh */
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// expected memory contents, same word layout as the responder
word_t modelMem [MEM_WORDS];
tag_t  modelTag [MODEL_SETS][WAYS];
logic  modelValid [MODEL_SETS][WAYS];
// last use time per way, smallest one is the LRU victim
int    modelStamp [MODEL_SETS][WAYS];
int    stampCount = 0;
logic  modelCe;

function automatic int modelSet(input addr_t a);
	return int'(a[9:4]);
endfunction

function automatic int modelHitWay(input addr_t a);
	int s;
	s = modelSet(a);
	for (int w = 0; w < WAYS; w++) begin
		if (modelValid[s][w] && modelTag[s][w] == a[28:10]) begin
			return w;
		end
	end
	return -1;
endfunction

function automatic int modelVictim(input int s);
	int v;
	v = 0;
	for (int w = 1; w < WAYS; w++) begin
		if (modelStamp[s][w] < modelStamp[s][v]) begin
			v = w;
		end
	end
	return v;
endfunction

task automatic modelTouch(input int s, input int w);
	stampCount++;
	modelStamp[s][w] = stampCount;
endtask

task automatic modelFill(input addr_t a, input int w);
	modelTag[modelSet(a)][w] = a[28:10];
	modelValid[modelSet(a)][w] = 1'b1;
endtask

// cleared order: way0 newest, way3 oldest
task automatic modelPurge();
	for (int s = 0; s < MODEL_SETS; s++) begin
		for (int w = 0; w < WAYS; w++) begin
			modelValid[s][w] = 1'b0;
			modelStamp[s][w] = -w;
		end
	end
endtask

task automatic modelWrite(input addr_t a, input word_t d, input byteEn_t be);
	for (int b = 0; b < 4; b++) begin
		if (be[b]) begin
			modelMem[memKey(a)][8*b +: 8] = d[8*b +: 8];
		end
	end
endtask

`endif

/* verif/cacheTb.sv */
`timescale 1ns/1ps

module cacheTb;
	import cacheAddrPkg::*;
	import cacheCtrlPkg::*;

	localparam int OFF_TX = 40;
	localparam int RAND_TX = 300;
	localparam int TAIL_TX = 20;
	localparam int SWEEP_LINES = 16;
	localparam int NUM_TX = OFF_TX + RAND_TX + TAIL_TX + 2 * SWEEP_LINES + 5;
	localparam int CYCLE_LIMIT = NUM_TX * 12 + 100;
	localparam int MEM_WORDS = 512;
	localparam int MODEL_SETS = 1 << INDEX_W;

	logic    CLK;
	logic    RST_N;
	addr_t   cbusAddr;
	word_t   cbusDataIn;
	word_t   cbusDataOut;
	logic    cbusWrite;
	logic    cbusReq;
	byteEn_t cbusByteEn;
	logic    cbusBusy;
	addr_t   ibusAddr;
	word_t   ibusDataIn;
	word_t   ibusDataOut;
	byteEn_t ibusByteEn;
	logic    ibusWrite;
	logic    ibusReq;
	logic    ibusLock;
	logic    ibusWait;

	word_t       respMem [MEM_WORDS];
	logic [31:0] lfsr = 32'd42;
	int          cycles = 0;
	logic        sawHit;

	// ibus beats of the current transaction
	addr_t   beatAddr [$];
	logic    beatWrite [$];
	logic    beatLock [$];
	word_t   beatData [$];
	byteEn_t beatBytes [$];

	cacheTop DUT (
		.CLK(CLK), .RST_N(RST_N),
		.cbusAddr(cbusAddr), .cbusDataIn(cbusDataIn), .cbusDataOut(cbusDataOut),
		.cbusWrite(cbusWrite), .cbusReq(cbusReq), .cbusByteEn(cbusByteEn),
		.cbusBusy(cbusBusy),
		.ibusAddr(ibusAddr), .ibusDataIn(ibusDataIn), .ibusDataOut(ibusDataOut),
		.ibusByteEn(ibusByteEn), .ibusWrite(ibusWrite), .ibusReq(ibusReq),
		.ibusLock(ibusLock), .ibusWait(ibusWait)
	);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run did not finish within %0d cycles", CYCLE_LIMIT);
			stopRun();
		end
	end

	task automatic stopRun();
		$display("Something failed");
		$fatal(1, "simulation aborted");
	endtask

	task automatic reportMismatch(input string msg);
		$display("FAIL at %0t: %s", $time, msg);
		stopRun();
	endtask

	task automatic checkWord(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			reportMismatch($sformatf("%s is %08h, expected %08h", what, got, exp));
		end
	endtask

	task automatic checkAddr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp) begin
			reportMismatch($sformatf("%s is %08h, expected %08h", what, got, exp));
		end
	endtask

	task automatic checkBytes(input byteEn_t got, input byteEn_t exp, input string what);
		if (got !== exp) begin
			reportMismatch($sformatf("%s is %04b, expected %04b", what, got, exp));
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	// galois LFSR stepped once per bit
	function automatic logic stepBit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 32'hD000_0001;
		end
		return b;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], stepBit()};
		end
		return r;
	endfunction

	// area key 0 cached, 1 uncached, 2 I/O
	function automatic addr_t makeAddr(input int area, input int tagSel, input int setSel,
			input int wordSel);
		logic [2:0] code;
		code = (area == 0) ? AREA_CACHED : ((area == 1) ? AREA_UNCACHED : AREA_IO);
		return {code, 16'h0000, 3'(tagSel), 4'h0, 2'(setSel), 2'(wordSel), 2'b00};
	endfunction

	function automatic int memKey(input addr_t a);
		logic [1:0] area;
		case (a[31:29])
			AREA_CACHED:   area = 2'd0;
			AREA_UNCACHED: area = 2'd1;
			default:       area = 2'd2;
		endcase
		return {area, a[12:10], a[5:2]};
	endfunction

	function automatic word_t fillPattern(input addr_t a);
		return (a * 32'h9E37_79B9) ^ {a[15:0], a[31:16]};
	endfunction

	function automatic word_t ccrValue(input logic ce, input logic cp);
		ccr_t v;
		v = '0;
		v[CCR_CE_BIT] = ce;
		v[CCR_CP_BIT] = cp;
		return {16'h0000, v, 8'h00};
	endfunction

	`include "cacheModel.svh"

	task automatic memInit();
		addr_t a;
		for (int area = 0; area < 3; area++) begin
			for (int t = 0; t < 8; t++) begin
				for (int s = 0; s < 4; s++) begin
					for (int w = 0; w < 4; w++) begin
						a = makeAddr(area, t, s, w);
						respMem[memKey(a)] = fillPattern(a);
						modelMem[memKey(a)] = fillPattern(a);
					end
				end
			end
		end
	endtask

	// ibus slave with random wait states
	task automatic driveResponder();
		ibusWait = randBits(2) == 2'b11;
		if (ibusReq && ibusAddr != CCR_ADDR) begin
			ibusDataIn = respMem[memKey(ibusAddr)];
		end else begin
			ibusDataIn = 32'h0BAD_F00D;
		end
	endtask

	task automatic recordBeat();
		if (ibusReq && !ibusWait) begin
			beatAddr.push_back(ibusAddr);
			beatWrite.push_back(ibusWrite);
			beatLock.push_back(ibusLock);
			beatData.push_back(ibusDataOut);
			beatBytes.push_back(ibusByteEn);
			if (ibusWrite && ibusAddr != CCR_ADDR) begin
				for (int b = 0; b < 4; b++) begin
					if (ibusByteEn[b]) begin
						respMem[memKey(ibusAddr)][8*b +: 8] = ibusDataOut[8*b +: 8];
					end
				end
			end
		end
	endtask

	task automatic access(input addr_t a, input logic wr, input word_t d, input byteEn_t be,
			output word_t rd, output int nCycles, output logic endBeat);
		logic done;
		int   beatsBefore;
		done = 1'b0;
		nCycles = 0;
		endBeat = 1'b0;
		beatAddr.delete();
		beatWrite.delete();
		beatLock.delete();
		beatData.delete();
		beatBytes.delete();
		while (!done) begin
			@(negedge CLK);
			cbusReq = 1'b1;
			cbusAddr = a;
			cbusWrite = wr;
			cbusDataIn = d;
			cbusByteEn = be;
			driveResponder();
			#2;
			beatsBefore = beatAddr.size();
			recordBeat();
			endBeat = beatAddr.size() != beatsBefore;
			nCycles++;
			done = !cbusBusy;
		end
		rd = cbusDataOut;
	endtask

	task automatic checkedAccess(input addr_t a, input logic wr, input word_t d,
			input byteEn_t be);
		word_t rd;
		word_t expected;
		ccr_t  ccrByte;
		logic  cacheable;
		logic  isCcr;
		int    way;
		int    s;
		int    nCycles;
		logic  endBeat;
		cacheable = modelCe && a[31:29] == AREA_CACHED;
		isCcr = a == CCR_ADDR && be[1];
		way = cacheable ? modelHitWay(a) : -1;
		s = modelSet(a);
		access(a, wr, d, be, rd, nCycles, endBeat);
		sawHit = beatAddr.size() == 0;
		if (!wr && way >= 0) begin
			checkFlag(logic'(nCycles == 1), 1'b1, "read hit done in the request cycle");
		end else begin
			checkFlag(endBeat, 1'b1, "completion on the accepted ibus beat");
		end
		if (wr) begin
			checkWord(word_t'(beatAddr.size()), 1, "ibus beat count of write");
			checkAddr(beatAddr[0], a, "ibus write address");
			checkFlag(beatWrite[0], 1'b1, "ibusWrite");
			checkWord(beatData[0], d, "ibus write data");
			checkBytes(beatBytes[0], be, "ibus byte enables");
			if (isCcr) begin
				modelCe = d[8 + CCR_CE_BIT];
				if (d[8 + CCR_CP_BIT]) begin
					modelPurge();
				end
			end else begin
				modelWrite(a, d, be);
				if (way >= 0) begin
					modelTouch(s, way);
				end
			end
		end else begin
			if (way >= 0) begin
				checkWord(word_t'(beatAddr.size()), 0, "ibus beat count of read hit");
				modelTouch(s, way);
			end else if (cacheable) begin
				checkWord(word_t'(beatAddr.size()), 4, "ibus beat count of line fill");
				for (int i = 0; i < 4; i++) begin
					// wraps from the word after the critical one
					checkAddr(beatAddr[i], {a[31:4], wordSel_t'(a[3:2] + 1 + i), 2'b00},
						"fill address");
					checkFlag(beatWrite[i], 1'b0, "ibusWrite during fill");
					checkFlag(beatLock[i], logic'(i < 3), "ibusLock during fill");
				end
				way = modelVictim(s);
				modelFill(a, way);
				modelTouch(s, way);
			end else begin
				checkWord(word_t'(beatAddr.size()), 1, "ibus beat count of pass read");
				checkAddr(beatAddr[0], a, "ibus read address");
				checkFlag(beatWrite[0], 1'b0, "ibusWrite on pass read");
				checkFlag(beatLock[0], 1'b0, "ibusLock on pass read");
			end
			if (isCcr) begin
				ccrByte = ccr_t'(modelCe) << CCR_CE_BIT;
				expected = {4{ccrByte}};
			end else begin
				expected = modelMem[memKey(a)];
			end
			checkWord(rd, expected, "read data");
		end
	endtask

	task automatic randomAccess(input logic allowWrite);
		addr_t   a;
		logic    wr;
		word_t   d;
		byteEn_t be;
		logic [1:0] area;
		area = randBits(2);
		a = makeAddr((area < 2) ? 0 : area - 1, randBits(3), randBits(2), randBits(2));
		wr = allowWrite && randBits(2) == 2'b00;
		d = randBits(32);
		be = randBits(4);
		if (be == '0) begin
			be = 4'b1111;
		end
		checkedAccess(a, wr, d, be);
	endtask

	initial begin
		RST_N = 1'b0;
		cbusReq = 1'b0;
		cbusAddr = '0;
		cbusDataIn = '0;
		cbusWrite = 1'b0;
		cbusByteEn = '0;
		ibusDataIn = '0;
		ibusWait = 1'b0;
		memInit();
		modelPurge();
		modelCe = 1'b0;
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;

		// cache still disabled
		for (int i = 0; i < OFF_TX; i++) begin
			randomAccess(1'b1);
		end

		checkedAccess(CCR_ADDR, 1'b1, ccrValue(1'b1, 1'b0), 4'b0010);
		for (int i = 0; i < RAND_TX; i++) begin
			randomAccess(1'b1);
		end

		checkedAccess(CCR_ADDR, 1'b0, '0, 4'b0010);
		checkedAccess(CCR_ADDR, 1'b1, ccrValue(1'b1, 1'b1), 4'b0010);
		// first touch of each line misses and the second one hits
		for (int pass = 0; pass < 2; pass++) begin
			for (int s = 0; s < 4; s++) begin
				for (int t = 0; t < 4; t++) begin
					checkedAccess(makeAddr(0, t, s, randBits(2)), 1'b0, '0, 4'b1111);
					checkFlag(sawHit, logic'(pass == 1), "hit after purge");
				end
			end
		end

		checkedAccess(CCR_ADDR, 1'b1, ccrValue(1'b0, 1'b0), 4'b0010);
		checkedAccess(CCR_ADDR, 1'b0, '0, 4'b0010);
		for (int i = 0; i < TAIL_TX; i++) begin
			randomAccess(1'b0);
		end

		@(negedge CLK);
		cbusReq = 1'b0;
		#2;
		checkFlag(cbusBusy, 1'b0, "cbusBusy with no request");
		checkFlag(ibusReq, 1'b0, "ibusReq after the last transfer");
		repeat (2) @(posedge CLK);
		$display("Everything OK");
		$finish;
	end

endmodule

/* sources.f */
logic/cacheAddrPkg.sv
logic/cacheCtrlPkg.sv
logic/lineFillCounter.sv
logic/tagArray.sv
logic/dataArray.sv
logic/lruStore.sv
logic/ccrRegister.sv
logic/cacheController.sv
logic/cacheTop.sv
+incdir+verif
verif/cacheTb.sv
